// ==== project.f ====
logic/afifo_pkg.sv
logic/afifo_dpram.sv
logic/afifo_gray_sync.sv
logic/afifo_wr_ptr.sv
logic/afifo_rd_ptr.sv
logic/afifo_top.sv
verification/afifo_clk_gen.sv
verification/afifo_tb.sv

// ==== verification/afifo_tb.sv ====
`timescale 1ns/1ps

module afifo_tb;

  logic                  wr_clk;
  logic                  rd_clk;
  logic                  wr_rst_n;
  afifo_pkg::fifo_wr_t   wr_req;
  afifo_pkg::wr_flags_t  wr_flags;
  logic                  rd_en;
  afifo_pkg::data_t      rd_data;
  afifo_pkg::rd_flags_t  rd_flags;

  // Reference model and scoreboard state
  afifo_pkg::data_t      ref_q[$];
  afifo_pkg::data_t      exp_word;
  logic                  rd_pending;
  logic                  rd_seen_empty;
  int                    wr_count;
  int                    rd_count;
  int                    wr_limit;
  integer                seed;
  string                 test_name;

  afifo_clk_gen u_clk_gen (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n)
  );

  afifo_top i_dut (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .wr_req   (wr_req),
    .wr_flags (wr_flags),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .rd_flags (rd_flags)
  );

  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH test=%s expected=0x%0h actual=0x%0h", test_name, expected, actual);
      stop_run();
    end
  endtask

  // The request already on the port is scored at this edge, then the next one is driven
  task automatic write_cycle(input logic en, input afifo_pkg::data_t data);
    @(posedge wr_clk);
    if (wr_req.en && !wr_flags.full) begin
      ref_q.push_back(wr_req.data);
      wr_count++;
    end
    wr_req.en   <= en && (wr_count < wr_limit);
    wr_req.data <= data;
  endtask

  // A word read at one edge is on rd_data at the next edge
  task automatic read_cycle(input logic en);
    @(posedge rd_clk);
    if (rd_pending) begin
      check_value(exp_word, rd_data);
      rd_pending = 1'b0;
    end
    rd_seen_empty = rd_flags.empty;
    if (rd_en && !rd_flags.empty) begin
      if (ref_q.size() == 0) begin
        $display("A read was accepted in %s while the reference queue held no data",
                 test_name);
        stop_run();
      end else begin
        exp_word   = ref_q.pop_front();
        rd_pending = 1'b1;
        rd_count++;
      end
    end
    rd_en <= en;
  endtask

  task automatic wait_not_empty();
    read_cycle(1'b0);
    while (rd_seen_empty) begin
      read_cycle(1'b0);
    end
  endtask

  // Stops once empty is seen with nothing left in the reference queue
  task automatic drain_fifo();
    read_cycle(1'b1);
    while (!(rd_seen_empty && ref_q.size() == 0)) begin
      read_cycle(1'b1);
    end
    read_cycle(1'b0);
  endtask

  // Long enough for both pointers to cross and the flags to follow
  task automatic settle();
    repeat (10) begin
      read_cycle(1'b0);
    end
  endtask

  task automatic test_reset();
    test_name = "test_reset";
    wait (wr_rst_n === 1'b1);
    read_cycle(1'b0);
    check_value(1, rd_flags.empty);
    check_value(1, rd_flags.aempty);
    check_value(0, rd_data);
    write_cycle(1'b0, '0);
    check_value(0, wr_flags.full);
    check_value(0, wr_flags.afull);
  endtask

  task automatic test_ordered();
    test_name = "test_ordered";
    repeat (10) begin
      write_cycle(1'b1, afifo_pkg::data_t'($random(seed)));
    end
    write_cycle(1'b0, '0);
    check_value(10, ref_q.size());
    wait_not_empty();
    drain_fifo();
  endtask

  task automatic test_full();
    test_name = "test_full";
    settle();
    repeat (16) begin
      write_cycle(1'b1, afifo_pkg::data_t'($random(seed)));
    end
    // This seventeenth request meets a full FIFO at the next edge
    write_cycle(1'b1, 8'hee);
    write_cycle(1'b0, '0);
    check_value(1, wr_flags.full);
    check_value(1, wr_flags.afull);
    check_value(16, ref_q.size());
    wait_not_empty();
    drain_fifo();
    check_value(1, rd_flags.empty);
  endtask

  task automatic test_read_empty();
    afifo_pkg::data_t last_word;
    int               start_count;
    test_name = "test_read_empty";
    settle();
    last_word   = rd_data;
    start_count = rd_count;
    repeat (5) begin
      read_cycle(1'b1);
    end
    read_cycle(1'b0);
    check_value(last_word, rd_data);
    check_value(1, rd_flags.empty);
    write_cycle(1'b1, ~last_word);
    write_cycle(1'b0, '0);
    wait_not_empty();
    drain_fifo();
    check_value(start_count + 1, rd_count);
  endtask

  task automatic test_stream();
    int rd_goal;
    test_name = "test_stream";
    settle();
    wr_limit = wr_count + 150;
    rd_goal  = rd_count + 150;
    fork
      begin
        while (wr_count < wr_limit) begin
          write_cycle(($random(seed) % 2) != 0, afifo_pkg::data_t'($random(seed)));
        end
      end
      begin
        while (rd_count < rd_goal) begin
          read_cycle(($random(seed) % 3) != 0);
        end
        read_cycle(1'b0);
      end
    join
    wr_limit = 32'h7fff_ffff;
    check_value(1, rd_flags.empty);
  endtask

  task automatic test_thresholds();
    int levels [4] = '{2, 3, 12, 15};
    test_name = "test_thresholds";
    foreach (levels[i]) begin
      settle();
      repeat (levels[i]) begin
        write_cycle(1'b1, afifo_pkg::data_t'($random(seed)));
      end
      write_cycle(1'b0, '0);
      repeat (10) begin
        read_cycle(1'b0);
      end
      check_value(levels[i] <= afifo_pkg::AEMPTY_LEVEL, rd_flags.aempty);
      write_cycle(1'b0, '0);
      check_value(levels[i] >= afifo_pkg::AFULL_LEVEL, wr_flags.afull);
      drain_fifo();
    end
  endtask

  initial begin
    seed          = 77773;
    wr_req        = '0;
    rd_en         = 1'b0;
    rd_pending    = 1'b0;
    rd_seen_empty = 1'b1;
    exp_word      = '0;
    wr_count      = 0;
    rd_count      = 0;
    wr_limit      = 32'h7fff_ffff;
    test_name     = "startup";
    test_reset();
    test_ordered();
    test_full();
    test_read_empty();
    test_stream();
    test_thresholds();
    $display("TEST PASSED");
    $finish;
  end

  // Budget of 400 transfers at 4 read clocks of 40 ns each, plus 2 us
  initial begin
    #(400 * 4 * 40 + 2000);
    $display("The run timed out before all tests finished");
    $display("TEST FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== verification/afifo_clk_gen.sv ====
`timescale 1ns/1ps

module afifo_clk_gen (
  output logic wr_clk,
  output logic rd_clk,
  output logic wr_rst_n
);

  // Read clock has a 40 ns period
  initial begin
    rd_clk = 1'b0;
    forever #20 rd_clk = ~rd_clk;
  end

  // Write clock has a 28 ns period
  initial begin
    wr_clk = 1'b0;
    forever #14 wr_clk = ~wr_clk;
  end

  initial begin
    wr_rst_n = 1'b0;
    repeat (2) @(posedge rd_clk);
    wr_rst_n <= 1'b1;
  end

endmodule

// ==== logic/afifo_top.sv ====
`timescale 1ns/1ps

module afifo_top (
  input  logic                  wr_clk,
  input  logic                  rd_clk,
  input  logic                  wr_rst_n,
  input  afifo_pkg::fifo_wr_t   wr_req,
  output afifo_pkg::wr_flags_t  wr_flags,
  input  logic                  rd_en,
  output afifo_pkg::data_t      rd_data,
  output afifo_pkg::rd_flags_t  rd_flags
);

  logic              ram_wr_en;
  afifo_pkg::addr_t  ram_wr_addr;
  logic              ram_rd_en;
  afifo_pkg::addr_t  ram_rd_addr;
  afifo_pkg::ptr_t   wr_gray;
  afifo_pkg::ptr_t   rd_gray;
  afifo_pkg::ptr_t   wr_ptr_rsync;
  afifo_pkg::ptr_t   rd_ptr_wsync;

  afifo_wr_ptr u_wr_ptr (
    .wr_clk       (wr_clk),
    .wr_rst_n     (wr_rst_n),
    .wr_req       (wr_req),
    .rd_ptr_wsync (rd_ptr_wsync),
    .ram_wr_en    (ram_wr_en),
    .ram_wr_addr  (ram_wr_addr),
    .wr_gray      (wr_gray),
    .wr_flags     (wr_flags)
  );

  afifo_rd_ptr u_rd_ptr (
    .rd_clk       (rd_clk),
    .wr_rst_n     (wr_rst_n),
    .rd_en        (rd_en),
    .wr_ptr_rsync (wr_ptr_rsync),
    .ram_rd_en    (ram_rd_en),
    .ram_rd_addr  (ram_rd_addr),
    .rd_gray      (rd_gray),
    .rd_flags     (rd_flags)
  );

  afifo_dpram u_dpram (
    .wr_clk   (wr_clk),
    .wr_en    (ram_wr_en),
    .wr_addr  (ram_wr_addr),
    .wr_data  (wr_req.data),
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .rd_en    (ram_rd_en),
    .rd_addr  (ram_rd_addr),
    .rd_data  (rd_data)
  );

  // Write pointer into the read domain
  afifo_gray_sync u_wr2rd_sync (
    .clk      (rd_clk),
    .wr_rst_n (wr_rst_n),
    .gray_in  (wr_gray),
    .bin_out  (wr_ptr_rsync)
  );

  // Read pointer into the write domain
  afifo_gray_sync u_rd2wr_sync (
    .clk      (wr_clk),
    .wr_rst_n (wr_rst_n),
    .gray_in  (rd_gray),
    .bin_out  (rd_ptr_wsync)
  );

endmodule

// ==== logic/afifo_rd_ptr.sv ====
`timescale 1ns/1ps

module afifo_rd_ptr (
  input  logic                  rd_clk,
  input  logic                  wr_rst_n,
  input  logic                  rd_en,
  input  afifo_pkg::ptr_t       wr_ptr_rsync,
  output logic                  ram_rd_en,
  output afifo_pkg::addr_t      ram_rd_addr,
  output afifo_pkg::ptr_t       rd_gray,
  output afifo_pkg::rd_flags_t  rd_flags
);

  afifo_pkg::ptr_t  rd_bin;
  afifo_pkg::ptr_t  rd_bin_nxt;
  afifo_pkg::ptr_t  rd_gray_nxt;
  afifo_pkg::ptr_t  rd_used_nxt;
  logic             empty_nxt;
  logic             aempty_nxt;

  // A read while empty does not touch the pointer or the RAM register
  assign ram_rd_en   = rd_en && !rd_flags.empty;
  assign ram_rd_addr = rd_bin[afifo_pkg::ADDR_WIDTH-1:0];

  assign rd_bin_nxt  = rd_bin + afifo_pkg::ptr_t'(ram_rd_en);
  assign rd_gray_nxt = (rd_bin_nxt >> 1) ^ rd_bin_nxt;

  // Empty when the read side has caught up, wrap bit included
  assign empty_nxt = (rd_bin_nxt == wr_ptr_rsync);

  // Counted against the delayed write pointer, so this may read low
  assign rd_used_nxt = wr_ptr_rsync - rd_bin_nxt;
  assign aempty_nxt  = (rd_used_nxt <= afifo_pkg::AEMPTY_LEVEL);

  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
    end
  end

  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_flags.empty  <= 1'b1;
      rd_flags.aempty <= 1'b1;
    end else begin
      rd_flags.empty  <= empty_nxt;
      rd_flags.aempty <= aempty_nxt;
    end
  end

endmodule

// ==== logic/afifo_wr_ptr.sv ====
`timescale 1ns/1ps

module afifo_wr_ptr (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  afifo_pkg::fifo_wr_t   wr_req,
  input  afifo_pkg::ptr_t       rd_ptr_wsync,
  output logic                  ram_wr_en,
  output afifo_pkg::addr_t      ram_wr_addr,
  output afifo_pkg::ptr_t       wr_gray,
  output afifo_pkg::wr_flags_t  wr_flags
);

  afifo_pkg::ptr_t  wr_bin;
  afifo_pkg::ptr_t  wr_bin_nxt;
  afifo_pkg::ptr_t  wr_gray_nxt;
  afifo_pkg::ptr_t  rd_gray_wsync;
  afifo_pkg::ptr_t  wr_used_nxt;
  logic             full_nxt;
  logic             afull_nxt;

  // Writes while full are dropped here
  assign ram_wr_en   = wr_req.en && !wr_flags.full;
  assign ram_wr_addr = wr_bin[afifo_pkg::ADDR_WIDTH-1:0];

  assign wr_bin_nxt  = wr_bin + afifo_pkg::ptr_t'(ram_wr_en);
  assign wr_gray_nxt = (wr_bin_nxt >> 1) ^ wr_bin_nxt;

  // Back to Gray form for the full compare
  assign rd_gray_wsync = (rd_ptr_wsync >> 1) ^ rd_ptr_wsync;

  // Full means one lap ahead, which in Gray code flips the top two bits
  assign full_nxt = (wr_gray_nxt == {~rd_gray_wsync[afifo_pkg::PTR_WIDTH-1 -: 2],
                                      rd_gray_wsync[afifo_pkg::PTR_WIDTH-3:0]});

  // The synchronized read pointer lags, so this count is never too low
  assign wr_used_nxt = wr_bin_nxt - rd_ptr_wsync;
  assign afull_nxt   = (wr_used_nxt >= afifo_pkg::AFULL_LEVEL);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt;
    end
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_flags <= '0;
    end else begin
      wr_flags.full  <= full_nxt;
      wr_flags.afull <= afull_nxt;
    end
  end

endmodule

// ==== logic/afifo_gray_sync.sv ====
`timescale 1ns/1ps

module afifo_gray_sync (
  input  logic             clk,
  input  logic             wr_rst_n,
  input  afifo_pkg::ptr_t  gray_in,
  output afifo_pkg::ptr_t  bin_out
);

  afifo_pkg::ptr_t gray_meta;
  afifo_pkg::ptr_t gray_sync;

  // Only one bit of a Gray pointer changes per step, so a late capture
  // gives either the old or the new value and never a mix
  always_ff @(posedge clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      gray_meta <= '0;
      gray_sync <= '0;
    end else begin
      gray_meta <= gray_in;
      gray_sync <= gray_meta;
    end
  end

  // Each binary bit is the XOR of all Gray bits at and above it
  always_comb begin
    for (int i = 0; i < afifo_pkg::PTR_WIDTH; i++) begin
      bin_out[i] = ^(gray_sync >> i);
    end
  end

endmodule

// ==== logic/afifo_dpram.sv ====
`timescale 1ns/1ps

module afifo_dpram (
  input  logic              wr_clk,
  input  logic              wr_en,
  input  afifo_pkg::addr_t  wr_addr,
  input  afifo_pkg::data_t  wr_data,
  input  logic              rd_clk,
  input  logic              wr_rst_n,
  input  logic              rd_en,
  input  afifo_pkg::addr_t  rd_addr,
  output afifo_pkg::data_t  rd_data
);

  afifo_pkg::data_t mem [afifo_pkg::FIFO_DEPTH];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // The output register only moves on an accepted read, so the last word
  // stays visible between reads
  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// ==== logic/afifo_pkg.sv ====
package afifo_pkg;

  // Word and storage sizes
  localparam int DATA_WIDTH = 8;
  localparam int FIFO_DEPTH = 16;
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  // One extra bit tells a full FIFO apart from an empty one
  localparam int PTR_WIDTH = ADDR_WIDTH + 1;

  // Flag thresholds, counted in words
  localparam int AFULL_LEVEL  = 12;
  localparam int AEMPTY_LEVEL = 2;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // Used both for binary and for Gray-coded pointers
  typedef logic [PTR_WIDTH-1:0] ptr_t;

  // Write request as seen at the top-level port
  typedef struct packed {
    logic  en;
    data_t data;
  } fifo_wr_t;

  // Write domain status
  typedef struct packed {
    logic full;
    logic afull;
  } wr_flags_t;

  // Read domain status
  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_flags_t;

endpackage
